/* verilog/mipsPkg.sv */
// Shared widths, encodings and pipeline register layouts for the MIPS core
// Every RTL file imports this package inside its module body
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// Primary opcodes of the kept subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdMem = 2'd1,
		fwdWb  = 2'd2
	} fwdSelT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic isBranch;
	} ctrlT;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT    ctrl;
		opcodeT  opcode;
		functT   funct;
		wordT    rsData;
		wordT    rtData;
		wordT    imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memRead;
		logic    memWrite;
		wordT    aluResult;
		wordT    storeData;
		regAddrT dest;
	} exMemT;

	// Register file write port and core result port
	typedef struct packed {
		logic    valid;
		regAddrT dest;
		wordT    data;
	} wbT;

endpackage

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
// Fetch stage with the PC and the fetch/decode register
// Holds on stall and loads a no-op into decode when a branch is taken
module fetchStage (
	input  logic          Clk,
	input  logic          arstN,
	input  logic          stall,
	input  logic          branchTaken,
	input  mipsPkg::wordT branchTarget,
	output mipsPkg::wordT imemAddr,
	input  mipsPkg::wordT imemData,
	output mipsPkg::ifIdT ifId
);
	import mipsPkg::*;

	wordT pc;
	wordT pcPlus4;
	wordT nextPc;

	assign pcPlus4 = pc + wordT'(4);
	// Branch resolved in decode overrides sequential flow
	assign nextPc = branchTaken ? branchTarget : pcPlus4;
	assign imemAddr = pc;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	// Wrong-path word is replaced by all zero
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			ifId <= '0;
		end else if (!stall) begin
			if (branchTaken) begin
				ifId <= '0;
			end else begin
				ifId.instr <= imemData;
				ifId.pcPlus4 <= pcPlus4;
			end
		end
	end

	// Branch targets are word offsets, so the PC never leaves word alignment
	pcAligned: assert property (@(posedge Clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps
// Thirty-two entry register file for the decode stage
// Register 0 is hard zero, a write in the same cycle is seen by the reads
module registerFile (
	input  logic            Clk,
	input  logic            arstN,
	input  mipsPkg::regAddrT rsAddr,
	input  mipsPkg::regAddrT rtAddr,
	output mipsPkg::wordT   rsData,
	output mipsPkg::wordT   rtData,
	input  mipsPkg::wbT     wb
);
	import mipsPkg::*;

	wordT regs [32];

	// Valid already excludes register 0
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Write-through bypass
	assign rsData = (rsAddr == '0) ? '0 :
		(wb.valid && wb.dest == rsAddr) ? wb.data : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		(wb.valid && wb.dest == rtAddr) ? wb.data : regs[rtAddr];

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
// Decode stage with main control, immediate extension and branch resolution
// Loads the decode/execute register, or a bubble while the hazard unit stalls
module decodeStage (
	input  logic             Clk,
	input  logic             arstN,
	input  logic             stall,
	input  mipsPkg::ifIdT    ifId,
	input  mipsPkg::wbT      wb,
	input  mipsPkg::wordT    memResult,
	input  logic             fwdBranchA,
	input  logic             fwdBranchB,
	output mipsPkg::regAddrT rsAddr,
	output mipsPkg::regAddrT rtAddr,
	output logic             isBranch,
	output logic             branchTaken,
	output mipsPkg::wordT    branchTarget,
	output mipsPkg::idExT    idEx
);
	import mipsPkg::*;

	opcodeT opcode;
	ctrlT   ctrl;
	wordT   imm;
	wordT   rsData;
	wordT   rtData;
	wordT   cmpA;
	wordT   cmpB;
	idExT   idExNext;

	assign opcode = opcodeT'(ifId.instr[31:26]);
	assign rsAddr = ifId.instr[25:21];
	assign rtAddr = ifId.instr[20:16];
	assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	registerFile regFile0 (
		.Clk    (Clk),
		.arstN  (arstN),
		.rsAddr (rsAddr),
		.rtAddr (rtAddr),
		.rsData (rsData),
		.rtData (rtData),
		.wb     (wb)
	);

	// Main control, unknown opcodes decode to a no-op
	always_comb begin
		ctrl = '0;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opBeq: ctrl.isBranch = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// Branch compare sees the memory-stage ALU result early
	assign cmpA = fwdBranchA ? memResult : rsData;
	assign cmpB = fwdBranchB ? memResult : rtData;
	assign isBranch = ctrl.isBranch;
	assign branchTaken = ctrl.isBranch && (cmpA == cmpB) && !stall;
	assign branchTarget = ifId.pcPlus4 + {imm[29:0], 2'b00};

	always_comb begin
		idExNext.ctrl = ctrl;
		idExNext.opcode = opcode;
		idExNext.funct = functT'(ifId.instr[5:0]);
		idExNext.rsData = rsData;
		idExNext.rtData = rtData;
		idExNext.imm = imm;
		idExNext.rs = rsAddr;
		idExNext.rt = rtAddr;
		idExNext.rd = ifId.instr[15:11];
	end

	// Bubble on stall keeps the stalled instruction in decode
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else if (stall) begin
			idEx <= '0;
		end else begin
			idEx <= idExNext;
		end
	end

	// Stalled instruction is still in decode for its retry
	holdOnStall: assert property (@(posedge Clk) disable iff (!arstN)
		stall |=> $stable(ifId));

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps
// Forwarding and stall control for the pipeline
// Compares register numbers across decode, execute, memory and writeback
module hazardUnit (
	input  mipsPkg::regAddrT idRs,
	input  mipsPkg::regAddrT idRt,
	input  logic             isBranch,
	input  mipsPkg::idExT    idEx,
	input  mipsPkg::exMemT   exMem,
	input  mipsPkg::wbT      wb,
	output mipsPkg::fwdSelT  fwdA,
	output mipsPkg::fwdSelT  fwdB,
	output logic             fwdBranchA,
	output logic             fwdBranchB,
	output logic             stall
);
	import mipsPkg::*;

	regAddrT exDest;
	logic    memHit;
	logic    exUsesId;
	logic    memUsesId;
	logic    loadUse;
	logic    branchWait;

	// Destination of the instruction now in execute
	assign exDest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
	assign memHit = exMem.regWrite && (exMem.dest != '0);

	// Memory stage wins over writeback
	assign fwdA = (memHit && exMem.dest == idEx.rs) ? fwdMem :
		(wb.valid && wb.dest == idEx.rs) ? fwdWb : fwdReg;
	assign fwdB = (memHit && exMem.dest == idEx.rt) ? fwdMem :
		(wb.valid && wb.dest == idEx.rt) ? fwdWb : fwdReg;

	// Branch compare takes only ALU results from memory
	assign fwdBranchA = memHit && !exMem.memRead && exMem.dest == idRs;
	assign fwdBranchB = memHit && !exMem.memRead && exMem.dest == idRt;

	assign exUsesId = (exDest != '0) && (exDest == idRs || exDest == idRt);
	assign memUsesId = (exMem.dest != '0) && (exMem.dest == idRs || exMem.dest == idRt);
	assign loadUse = idEx.ctrl.memRead && exUsesId;
	// Operand still in execute, or a load still in memory
	assign branchWait = isBranch &&
		((idEx.ctrl.regWrite && exUsesId) || (exMem.memRead && memUsesId));
	assign stall = loadUse || branchWait;

	// The load-use stall keeps a load out of memory-stage forwarding
	always_comb begin
		noLoadFwd: assert final ((fwdA != fwdMem && fwdB != fwdMem) || !exMem.memRead);
	end

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps
// Execute stage with operand forwarding, ALU control and the ALU
// Result, store data and destination go to the execute/memory register
module executeStage (
	input  logic            Clk,
	input  logic            arstN,
	input  mipsPkg::idExT   idEx,
	input  mipsPkg::fwdSelT fwdA,
	input  mipsPkg::fwdSelT fwdB,
	input  mipsPkg::wbT     wb,
	output mipsPkg::exMemT  exMem
);
	import mipsPkg::*;

	wordT    opA;
	wordT    opB;
	wordT    aluB;
	wordT    result;
	aluOpT   aluOp;
	regAddrT dest;

	// Operand A source
	always_comb begin
		case (fwdA)
			fwdMem: opA = exMem.aluResult;
			fwdWb: opA = wb.data;
			default: opA = idEx.rsData;
		endcase
	end

	// Operand B source, also the store data
	always_comb begin
		case (fwdB)
			fwdMem: opB = exMem.aluResult;
			fwdWb: opB = wb.data;
			default: opB = idEx.rtData;
		endcase
	end

	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

	// ALU control, loads and stores use add for the address
	always_comb begin
		aluOp = aluAdd;
		if (idEx.opcode == opRType) begin
			case (idEx.funct)
				fnSub: aluOp = aluSub;
				fnAnd: aluOp = aluAnd;
				fnOr: aluOp = aluOr;
				fnSlt: aluOp = aluSlt;
				default: aluOp = aluAdd;
			endcase
		end
	end

	always_comb begin
		case (aluOp)
			aluSub: result = opA - aluB;
			aluAnd: result = opA & aluB;
			aluOr: result = opA | aluB;
			aluSlt: result = {31'b0, $signed(opA) < $signed(aluB)};
			default: result = opA + aluB;
		endcase
	end

	assign dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.aluResult <= result;
			exMem.storeData <= opB;
			exMem.dest <= dest;
		end
	end

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ps
// Memory stage with word-addressed data memory and the memory/writeback register
// Drives the writeback bus, picking load data or ALU result
module memoryStage #(
	parameter int dataWords = 64
) (
	input  logic           Clk,
	input  logic           arstN,
	input  mipsPkg::exMemT exMem,
	output mipsPkg::wbT    wb
);
	import mipsPkg::*;

	localparam int addrBits = $clog2(dataWords);

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		regAddrT dest;
		wordT    loadData;
		wordT    aluResult;
	} memWbT;

	wordT                mem [dataWords];
	logic [addrBits-1:0] wordAddr;
	wordT                readData;
	memWbT               memWb;

	// Byte address to word index
	assign wordAddr = exMem.aluResult[addrBits+1:2];
	assign readData = mem[wordAddr];

	always_ff @(posedge Clk) begin
		if (exMem.memWrite) begin
			mem[wordAddr] <= exMem.storeData;
		end
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.dest <= exMem.dest;
			memWb.loadData <= readData;
			memWb.aluResult <= exMem.aluResult;
		end
	end

	// Writes to register 0 never show up
	assign wb.valid = memWb.regWrite && (memWb.dest != '0);
	assign wb.dest = memWb.dest;
	assign wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;

	noReadWrite: assert property (@(posedge Clk) disable iff (!arstN)
		!(exMem.memRead && exMem.memWrite));

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ps
// Top of the five-stage MIPS integer pipeline
// Instruction memory sits outside, results leave through the writeback port
module mipsCore #(
	parameter int dataWords = 64
) (
	input  logic          Clk,
	input  logic          arstN,
	output mipsPkg::wordT imemAddr,
	input  mipsPkg::wordT imemData,
	output mipsPkg::wbT   wb
);
	import mipsPkg::*;

	ifIdT    ifId;
	idExT    idEx;
	exMemT   exMem;
	logic    stall;
	logic    branchTaken;
	wordT    branchTarget;
	regAddrT idRs;
	regAddrT idRt;
	logic    isBranch;
	fwdSelT  fwdA;
	fwdSelT  fwdB;
	logic    fwdBranchA;
	logic    fwdBranchB;

	fetchStage fetch0 (
		.Clk          (Clk),
		.arstN        (arstN),
		.stall        (stall),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.imemAddr     (imemAddr),
		.imemData     (imemData),
		.ifId         (ifId)
	);

	// Memory-stage ALU result feeds the branch compare
	decodeStage decode0 (
		.Clk          (Clk),
		.arstN        (arstN),
		.stall        (stall),
		.ifId         (ifId),
		.wb           (wb),
		.memResult    (exMem.aluResult),
		.fwdBranchA   (fwdBranchA),
		.fwdBranchB   (fwdBranchB),
		.rsAddr       (idRs),
		.rtAddr       (idRt),
		.isBranch     (isBranch),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.idEx         (idEx)
	);

	hazardUnit hazard0 (
		.idRs       (idRs),
		.idRt       (idRt),
		.isBranch   (isBranch),
		.idEx       (idEx),
		.exMem      (exMem),
		.wb         (wb),
		.fwdA       (fwdA),
		.fwdB       (fwdB),
		.fwdBranchA (fwdBranchA),
		.fwdBranchB (fwdBranchB),
		.stall      (stall)
	);

	executeStage execute0 (
		.Clk   (Clk),
		.arstN (arstN),
		.idEx  (idEx),
		.fwdA  (fwdA),
		.fwdB  (fwdB),
		.wb    (wb),
		.exMem (exMem)
	);

	memoryStage #(
		.dataWords (dataWords)
	) memory0 (
		.Clk   (Clk),
		.arstN (arstN),
		.exMem (exMem),
		.wb    (wb)
	);

endmodule

/* tests/mipsProgramTable.svh */
// Program run by the core testbench and the writeback expected from each word
// Included in the testbench module body; fillProgram loads the table before reset ends
`ifndef mipsProgramTableSvh
`define mipsProgramTableSvh

	// One program word and the writeback it should cause
	typedef struct packed {
		logic [31:0] instr;
		int          testNum;
		logic [4:0]  dest;
		logic [31:0] value;
		logic        noWb;
	} progEntryT;

	localparam int progLen = 24;

	// Primary opcodes and R-type function codes
	localparam logic [5:0] addiCode = 6'h08;
	localparam logic [5:0] lwCode = 6'h23;
	localparam logic [5:0] swCode = 6'h2b;
	localparam logic [5:0] beqCode = 6'h04;
	localparam logic [5:0] addFn = 6'h20;
	localparam logic [5:0] subFn = 6'h22;
	localparam logic [5:0] andFn = 6'h24;
	localparam logic [5:0] orFn = 6'h25;
	localparam logic [5:0] sltFn = 6'h2a;

	progEntryT progTable [progLen];
	int        progCount;

	function automatic logic [31:0] encodeR(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'h00, funct};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic addEntry(input logic [31:0] instr, input int testNum, input logic [4:0] dest,
		input logic [31:0] value, input logic noWb);
		progTable[progCount] = '{instr, testNum, dest, value, noWb};
		progCount++;
	endtask

	task automatic fillProgram();
		progCount = 0;
		// Dependent ALU chain, forwards from memory and writeback
		addEntry(encodeI(addiCode, 5'd0, 5'd1, 16'd5), 1, 5'd1, 32'd5, 1'b0);
		// Negative immediate, 5 - 3
		addEntry(encodeI(addiCode, 5'd1, 5'd2, 16'hfffd), 1, 5'd2, 32'd2, 1'b0);
		addEntry(encodeR(addFn, 5'd1, 5'd2, 5'd3), 1, 5'd3, 32'd7, 1'b0);
		addEntry(encodeR(subFn, 5'd3, 5'd1, 5'd4), 1, 5'd4, 32'd2, 1'b0);
		addEntry(encodeR(sltFn, 5'd4, 5'd3, 5'd5), 1, 5'd5, 32'd1, 1'b0);
		addEntry(encodeR(orFn, 5'd3, 5'd4, 5'd6), 1, 5'd6, 32'd7, 1'b0);
		addEntry(encodeR(andFn, 5'd6, 5'd2, 5'd7), 1, 5'd7, 32'd2, 1'b0);
		addEntry(encodeI(addiCode, 5'd0, 5'd8, 16'hfffc), 1, 5'd8, 32'hfffffffc, 1'b0);
		// Signed compare, -4 < 5
		addEntry(encodeR(sltFn, 5'd8, 5'd1, 5'd9), 1, 5'd9, 32'd1, 1'b0);
		// Store then load at byte 0x44, then load-use
		addEntry(encodeI(addiCode, 5'd0, 5'd10, 16'h0040), 2, 5'd10, 32'h40, 1'b0);
		addEntry(encodeI(swCode, 5'd10, 5'd3, 16'd4), 2, 5'd0, 32'd0, 1'b1);
		addEntry(encodeI(lwCode, 5'd10, 5'd11, 16'd4), 2, 5'd11, 32'd7, 1'b0);
		addEntry(encodeR(addFn, 5'd11, 5'd1, 5'd12), 2, 5'd12, 32'd12, 1'b0);
		addEntry(encodeI(swCode, 5'd10, 5'd12, 16'd8), 2, 5'd0, 32'd0, 1'b1);
		addEntry(encodeI(lwCode, 5'd10, 5'd13, 16'd8), 2, 5'd13, 32'd12, 1'b0);
		// Taken beq on a fresh operand, skips one word
		addEntry(encodeI(addiCode, 5'd0, 5'd14, 16'd12), 3, 5'd14, 32'd12, 1'b0);
		addEntry(encodeI(beqCode, 5'd14, 5'd13, 16'd1), 3, 5'd0, 32'd0, 1'b1);
		addEntry(encodeI(addiCode, 5'd0, 5'd15, 16'd99), 3, 5'd0, 32'd0, 1'b1);
		addEntry(encodeI(addiCode, 5'd0, 5'd15, 16'd33), 3, 5'd15, 32'd33, 1'b0);
		// Not taken, 33 against zero
		addEntry(encodeI(beqCode, 5'd15, 5'd0, 16'd1), 4, 5'd0, 32'd0, 1'b1);
		addEntry(encodeI(addiCode, 5'd15, 5'd16, 16'd1), 4, 5'd16, 32'd34, 1'b0);
		// Writes to register 0 vanish
		addEntry(encodeI(addiCode, 5'd0, 5'd0, 16'd77), 5, 5'd0, 32'd0, 1'b1);
		addEntry(encodeR(addFn, 5'd0, 5'd16, 5'd18), 5, 5'd18, 32'd34, 1'b0);
		addEntry(encodeR(orFn, 5'd0, 5'd0, 5'd19), 5, 5'd19, 32'd0, 1'b0);
	endtask

`endif

/* tests/mipsCoreTb.sv */
`timescale 1ns/1ps
// Testbench for the MIPS core; runs the program table and checks every writeback
// Instruction memory is a combinational lookup of the same table
module mipsCoreTb;
	import mipsPkg::*;

	`include "mipsProgramTable.svh"

	localparam int resetCycles = 5;
	localparam int trailCycles = 12;

	logic Clk;
	logic arstN;
	wordT imemAddr;
	wordT imemData;
	wbT   wb;

	int errCount;
	int testsPassed;
	int testsFailed;

	mipsCore #(
		.dataWords (64)
	) dut0 (
		.Clk      (Clk),
		.arstN    (arstN),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.wb       (wb)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// Past the table end the core fetches no-ops
	always_comb begin
		int unsigned idx;
		idx = imemAddr >> 2;
		if (idx < progLen) begin
			imemData = progTable[idx].instr;
		end else begin
			imemData = '0;
		end
	end

	task automatic checkValue(input string sigName, input wordT got, input wordT expected);
		if (got !== expected) begin
			$display("ERR %0t %s got %h expected %h", $time, sigName, got, expected);
			errCount++;
		end
	endtask

	task automatic reportTest(input int testNum, input int errs);
		if (errs == 0) begin
			$display("Test %0d passed", testNum);
			testsPassed++;
		end else begin
			$display("Test %0d failed with %0d errors", testNum, errs);
			testsFailed++;
		end
	endtask

	// Outputs settle after the rising edge, so look at the falling edge
	task automatic waitWriteback();
		do begin
			@(negedge Clk);
		end while (!wb.valid);
	endtask

	initial begin
		int startErr;
		int quietErr;
		arstN = 1'b0;
		errCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		fillProgram();

		// No writeback while in reset, PC parked at zero
		for (int i = 0; i < resetCycles; i++) begin
			@(negedge Clk);
			checkValue("wb.valid", 32'(wb.valid), 32'd0);
			checkValue("imemAddr", imemAddr, 32'd0);
		end
		quietErr = errCount;
		@(posedge Clk);
		#1 arstN = 1'b1;

		// Writebacks in program order
		startErr = errCount;
		for (int i = 0; i < progLen; i++) begin
			if (!progTable[i].noWb) begin
				waitWriteback();
				checkValue("wb.dest", 32'(wb.dest), 32'(progTable[i].dest));
				checkValue("wb.data", wb.data, progTable[i].value);
			end
			if (i == progLen - 1 || progTable[i + 1].testNum != progTable[i].testNum) begin
				reportTest(progTable[i].testNum, errCount - startErr);
				startErr = errCount;
			end
		end

		// Trailing no-ops stay silent
		for (int i = 0; i < trailCycles; i++) begin
			@(negedge Clk);
			checkValue("wb.valid", 32'(wb.valid), 32'd0);
		end
		reportTest(6, quietErr + errCount - startErr);

		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Generous budget of eight cycles per word plus reset
	initial begin
		repeat (resetCycles + progLen * 8) @(posedge Clk);
		$display("Timeout, the core stopped producing writebacks");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* src.f */
+incdir+tests
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
tests/mipsCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module mipsCoreTb -o mipsCoreSim

./obj_dir/mipsCoreSim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
